/* source/ipv4_checksum_update.sv */
////////////////////////////////////////////////////////////////////////////
// One registered RFC 1624 incremental checksum update stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "ipv4_rewrite_params.svh"

module ipv4_checksum_update (
    input  logic                         update_req,
    input  logic                         rst,
    input  ipv4_rewrite_pkg::rw_stage_t  in_item,
    input  logic                         sel_b,
    output ipv4_rewrite_pkg::rw_stage_t  out_item
);

    import ipv4_rewrite_pkg::*;

    ////////////////////////////////////////////////////////////////////////
    // Declarations
    ////////////////////////////////////////////////////////////////////////

    // Change handled by this instance
    word_change_t            chg;
    logic [`IPV4_WORD_W-1:0] cks_old;
    logic [`IPV4_WORD_W-1:0] cks_sum;
    logic [`IPV4_WORD_W-1:0] cks_new;
    rw_stage_t               item_nxt;

    // Tied per instance, A in the first stage and B in the second
    assign chg     = sel_b ? in_item.chg_b : in_item.chg_a;
    assign cks_old = in_item.hdr.checksum;

    ////////////////////////////////////////////////////////////////////////
    // Incremental update
    ////////////////////////////////////////////////////////////////////////

    // HC' = ~(~HC + ~m + m'), eq. 3
    always_comb begin
        cks_sum = ones_add(~cks_old, ~chg.old_word);
        cks_sum = ones_add(cks_sum, chg.new_word);
        cks_new = ~cks_sum;
    end

    // Disabled change leaves the checksum as it came in
    always_comb begin
        item_nxt = in_item;
        if (chg.en) begin
            item_nxt.hdr.checksum = cks_new;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge update_req) begin
        out_item <= item_nxt;
        if (rst) begin
            out_item.valid <= 1'b0;
        end
    end

endmodule

/* source/ipv4_checksum_verify.sv */
////////////////////////////////////////////////////////////////////////////
// Full one's-complement check of the arriving header
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "ipv4_rewrite_params.svh"

module ipv4_checksum_verify (
    input  logic                         update_req,
    input  logic                         rst,
    input  ipv4_rewrite_pkg::ipv4_hdr_t  hdr,
    output logic                         bad
);

    import ipv4_rewrite_pkg::*;

    ////////////////////////////////////////////////////////////////////////
    // Declarations
    ////////////////////////////////////////////////////////////////////////

    // Flat view of the header, word 0 in the top bits
    logic [`IPV4_WORD_W*`IPV4_HDR_WORDS-1:0] hdr_bits;
    // Running sum over all ten words
    logic [`IPV4_WORD_W-1:0]                 hdr_sum;
    logic                                    bad_nxt;

    assign hdr_bits = hdr;

    ////////////////////////////////////////////////////////////////////////
    // Fold
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        hdr_sum = '0;
        // Checksum word is included, so a good header folds to all ones
        for (int i = 0; i < `IPV4_HDR_WORDS; i++) begin
            hdr_sum = ones_add(hdr_sum,
                hdr_bits[(`IPV4_HDR_WORDS-1-i)*`IPV4_WORD_W +: `IPV4_WORD_W]);
        end
    end

    // Anything short of 0xFFFF means the header was damaged upstream
    assign bad_nxt = (hdr_sum != {`IPV4_WORD_W{1'b1}});

    ////////////////////////////////////////////////////////////////////////
    // Flag register
    ////////////////////////////////////////////////////////////////////////

    // Same cycle as the field select stage
    always_ff @(posedge update_req) begin
        if (rst) begin
            bad <= 1'b0;
        end else begin
            bad <= bad_nxt;
        end
    end

endmodule

/* source/ipv4_field_select.sv */
////////////////////////////////////////////////////////////////////////////
// Opcode decode, header field rewrite and checksum word-change capture
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "ipv4_rewrite_params.svh"

module ipv4_field_select (
    input  logic                            update_req,
    input  logic                            rst,
    input  ipv4_rewrite_pkg::rewrite_req_t  req,
    output ipv4_rewrite_pkg::rw_stage_t     stage
);

    import ipv4_rewrite_pkg::*;

    ////////////////////////////////////////////////////////////////////////
    // Declarations
    ////////////////////////////////////////////////////////////////////////

    // Header after the field edit, checksum still the incoming one
    ipv4_hdr_t    hdr_nxt;
    // First and second word changes seen by the update stages
    word_change_t chg_a_nxt;
    word_change_t chg_b_nxt;
    rw_stage_t    stage_nxt;

    ////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        hdr_nxt   = req.hdr;
        chg_a_nxt = '0;
        chg_b_nxt = '0;

        case (req.op)
            OP_DEC_TTL: begin
                // TTL of 0 saturates, header left alone
                if (req.hdr.ttl != 8'd0) begin
                    hdr_nxt.ttl        = req.hdr.ttl - 8'd1;
                    // Word 4 is {ttl, protocol}
                    chg_a_nxt.en       = 1'b1;
                    chg_a_nxt.old_word = {req.hdr.ttl, req.hdr.protocol};
                    chg_a_nxt.new_word = {hdr_nxt.ttl, req.hdr.protocol};
                end
            end

            OP_SET_TOS: begin
                hdr_nxt.tos        = req.arg[7:0];
                // Word 0 is {ver_ihl, tos}
                chg_a_nxt.en       = 1'b1;
                chg_a_nxt.old_word = {req.hdr.ver_ihl, req.hdr.tos};
                chg_a_nxt.new_word = {req.hdr.ver_ihl, req.arg[7:0]};
            end

            OP_SET_SRC: begin
                hdr_nxt.src_addr   = req.arg;
                // Words 6 and 7, upper half first
                chg_a_nxt.en       = 1'b1;
                chg_a_nxt.old_word = req.hdr.src_addr[`IPV4_ADDR_W-1 -: `IPV4_WORD_W];
                chg_a_nxt.new_word = req.arg[`IPV4_ADDR_W-1 -: `IPV4_WORD_W];
                chg_b_nxt.en       = 1'b1;
                chg_b_nxt.old_word = req.hdr.src_addr[`IPV4_WORD_W-1:0];
                chg_b_nxt.new_word = req.arg[`IPV4_WORD_W-1:0];
            end

            OP_SET_DST: begin
                hdr_nxt.dst_addr   = req.arg;
                // Words 8 and 9
                chg_a_nxt.en       = 1'b1;
                chg_a_nxt.old_word = req.hdr.dst_addr[`IPV4_ADDR_W-1 -: `IPV4_WORD_W];
                chg_a_nxt.new_word = req.arg[`IPV4_ADDR_W-1 -: `IPV4_WORD_W];
                chg_b_nxt.en       = 1'b1;
                chg_b_nxt.old_word = req.hdr.dst_addr[`IPV4_WORD_W-1:0];
                chg_b_nxt.new_word = req.arg[`IPV4_WORD_W-1:0];
            end

            // Pass through untouched
            OP_NONE: ;
            default: ;
        endcase
    end

    // Bad flag is filled in by the top from the verifier
    always_comb begin
        stage_nxt       = '0;
        stage_nxt.valid = req.valid;
        stage_nxt.hdr   = hdr_nxt;
        stage_nxt.chg_a = chg_a_nxt;
        stage_nxt.chg_b = chg_b_nxt;
        stage_nxt.bad   = 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge update_req) begin
        stage <= stage_nxt;
        // Only valid is cleared
        if (rst) begin
            stage.valid <= 1'b0;
        end
    end

endmodule

/* source/ipv4_header_rewriter.sv */
////////////////////////////////////////////////////////////////////////////
// IPv4 header rewriter top, select and verify then two checksum stages
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module ipv4_header_rewriter (
    input  logic                            update_req,
    input  logic                            rst,
    input  ipv4_rewrite_pkg::rewrite_req_t  req,
    output ipv4_rewrite_pkg::rewrite_rsp_t  rsp
);

    import ipv4_rewrite_pkg::*;

    ////////////////////////////////////////////////////////////////////////
    // Declarations
    ////////////////////////////////////////////////////////////////////////

    // Output of field select, bad still 0
    rw_stage_t stage_sel;
    // Arriving-header check, aligned with stage_sel
    logic      bad_flag;
    // Select output with the bad flag folded in
    rw_stage_t stage_merged;
    // After the first and second checksum updates
    rw_stage_t stage_a;
    rw_stage_t stage_b;

    ////////////////////////////////////////////////////////////////////////
    // Stage 1: rewrite and verify in parallel
    ////////////////////////////////////////////////////////////////////////

    ipv4_field_select u_select (
        .update_req (update_req),
        .rst        (rst),
        .req        (req),
        .stage      (stage_sel)
    );

    // Looks at the header as it arrived, not the rewritten one
    ipv4_checksum_verify u_verify (
        .update_req (update_req),
        .rst        (rst),
        .hdr        (req.hdr),
        .bad        (bad_flag)
    );

    // Both registered on the same edge, so no realignment needed
    always_comb begin
        stage_merged     = stage_sel;
        stage_merged.bad = bad_flag;
    end

    ////////////////////////////////////////////////////////////////////////
    // Stages 2 and 3: chained incremental checksum updates
    ////////////////////////////////////////////////////////////////////////

    // First word change, the only one for TTL and TOS
    ipv4_checksum_update u_update_a (
        .update_req (update_req),
        .rst        (rst),
        .in_item    (stage_merged),
        .sel_b      (1'b0),
        .out_item   (stage_a)
    );

    // Lower address word, passes through when chg_b is off
    ipv4_checksum_update u_update_b (
        .update_req (update_req),
        .rst        (rst),
        .in_item    (stage_a),
        .sel_b      (1'b1),
        .out_item   (stage_b)
    );

    ////////////////////////////////////////////////////////////////////////
    // Response
    ////////////////////////////////////////////////////////////////////////

    // Word changes are internal and dropped here
    assign rsp.valid = stage_b.valid;
    assign rsp.hdr   = stage_b.hdr;
    assign rsp.bad   = stage_b.bad;

endmodule

/* source/ipv4_rewrite_params.svh */
////////////////////////////////////////////////////////////////////////////
// Fixed IPv4 header widths and rewriter pipeline depth
////////////////////////////////////////////////////////////////////////////

`ifndef IPV4_REWRITE_PARAMS_SVH
`define IPV4_REWRITE_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Header geometry
////////////////////////////////////////////////////////////////////////////

// Checksum arithmetic works on 16-bit words
`define IPV4_WORD_W 16

// 20-byte header, no options (IHL = 5)
`define IPV4_HDR_WORDS 10

// Source and destination address width
`define IPV4_ADDR_W 32

////////////////////////////////////////////////////////////////////////////
// Pipeline
////////////////////////////////////////////////////////////////////////////

// Request valid at edge N shows up on rsp at edge N+3
// Select/verify, update A, update B
`define IPV4_RW_LATENCY 3

`endif

/* source/ipv4_rewrite_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Header, opcode and stream types plus one's-complement adder
////////////////////////////////////////////////////////////////////////////

`include "ipv4_rewrite_params.svh"

package ipv4_rewrite_pkg;

    ////////////////////////////////////////////////////////////////////////
    // Header layout
    ////////////////////////////////////////////////////////////////////////

    // Wire order, first byte in the top bits
    typedef struct packed {
        logic [7:0]              ver_ihl;
        logic [7:0]              tos;
        logic [15:0]             total_len;
        logic [15:0]             ident;
        logic [15:0]             flags_frag;
        logic [7:0]              ttl;
        logic [7:0]              protocol;
        logic [`IPV4_WORD_W-1:0] checksum;
        logic [`IPV4_ADDR_W-1:0] src_addr;
        logic [`IPV4_ADDR_W-1:0] dst_addr;
    } ipv4_hdr_t;

    // Rewrite opcodes, codes 5..7 act as no-op
    typedef enum logic [2:0] {
        OP_NONE    = 3'd0,
        OP_DEC_TTL = 3'd1,
        OP_SET_TOS = 3'd2,
        OP_SET_SRC = 3'd3,
        OP_SET_DST = 3'd4
    } rewrite_op_e;

    ////////////////////////////////////////////////////////////////////////
    // Streams and pipeline items
    ////////////////////////////////////////////////////////////////////////

    // Inbound beat, valid-only
    typedef struct packed {
        logic                    valid;
        rewrite_op_e             op;
        logic [`IPV4_ADDR_W-1:0] arg;
        ipv4_hdr_t               hdr;
    } rewrite_req_t;

    // One 16-bit word swap as seen by the checksum
    typedef struct packed {
        logic                    en;
        logic [`IPV4_WORD_W-1:0] old_word;
        logic [`IPV4_WORD_W-1:0] new_word;
    } word_change_t;

    // Item carried between stages
    // hdr.checksum is patched as it moves down the chain
    typedef struct packed {
        logic         valid;
        ipv4_hdr_t    hdr;
        word_change_t chg_a;
        word_change_t chg_b;
        logic         bad;
    } rw_stage_t;

    // Outbound beat, no ready
    typedef struct packed {
        logic      valid;
        ipv4_hdr_t hdr;
        logic      bad;
    } rewrite_rsp_t;

    ////////////////////////////////////////////////////////////////////////
    // Arithmetic
    ////////////////////////////////////////////////////////////////////////

    // 16-bit one's-complement add, carry out wraps back into bit 0
    function automatic logic [`IPV4_WORD_W-1:0] ones_add(
        input logic [`IPV4_WORD_W-1:0] a,
        input logic [`IPV4_WORD_W-1:0] b
    );
        logic [`IPV4_WORD_W:0] t;
        t = {1'b0, a} + {1'b0, b};
        // Max low part is 0xFFFE when carry set, so no second wrap
        return t[`IPV4_WORD_W-1:0] + {{(`IPV4_WORD_W-1){1'b0}}, t[`IPV4_WORD_W]};
    endfunction

endpackage

/* verif/tb_clock_gen.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench clock (20 ns period) and 3-cycle synchronous reset
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_clock_gen (
    output logic update_req,
    output logic rst
);

    // 10 ns high, 10 ns low
    initial begin
        update_req = 1'b0;
        forever #10 update_req = ~update_req;
    end

    // Held over three rising edges, dropped on a falling edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge update_req);
        @(negedge update_req);
        rst = 1'b0;
    end

endmodule

/* verif/tb_ipv4_header_rewriter.sv */
////////////////////////////////////////////////////////////////////////////
// IPv4 header rewriter testbench, random headers checked against a model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`include "ipv4_rewrite_params.svh"

module tb_ipv4_header_rewriter;

    import ipv4_rewrite_pkg::*;

    // Requests per random test
    localparam int N_REQ   = 60;
    // Five random tests, up to 4 cycles per request, plus drain and slack
    localparam int TIMEOUT = 5 * N_REQ * 4 + 6 * (`IPV4_RW_LATENCY + 8) + 200;

    // Expected beat and the cycle it is due in
    typedef struct packed {
        logic [31:0] due;
        ipv4_hdr_t   hdr;
        logic        bad;
    } exp_t;

    logic         update_req;
    logic         rst;
    rewrite_req_t req;
    rewrite_rsp_t rsp;
    int unsigned  cycle   = 0;
    int           errors  = 0;
    int           checked = 0;
    int           tests   = 0;
    exp_t         expect_q[$];

    tb_clock_gen u_clk (.update_req(update_req), .rst(rst));

    ipv4_header_rewriter u_dut (
        .update_req (update_req),
        .rst        (rst),
        .req        (req),
        .rsp        (rsp)
    );

    // Rising edges seen so far
    always @(posedge update_req) begin
        cycle <= cycle + 1;
    end

    ////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////

    // Fold carries back in until the sum fits 16 bits
    function automatic logic [15:0] fold(input logic [31:0] acc);
        while (acc[31:16] != 16'h0)
            acc = acc[15:0] + acc[31:16];
        return acc[15:0];
    endfunction

    // One's-complement sum of all ten words, 0xFFFF when intact
    function automatic logic [15:0] hdr_sum(input ipv4_hdr_t h);
        logic [159:0] bits;
        logic [31:0]  acc;
        bits = h;
        acc  = 32'h0;
        for (int i = 0; i < `IPV4_HDR_WORDS; i++)
            acc = acc + bits[159 - 16*i -: 16];
        return fold(acc);
    endfunction

    // RFC 1624 eq. 3
    function automatic logic [15:0] adjust(input logic [15:0] hc, input logic [15:0] m,
                                           input logic [15:0] m_new);
        return ~fold({16'h0, ~hc} + {16'h0, ~m} + {16'h0, m_new});
    endfunction

    function automatic ipv4_hdr_t rewrite(input rewrite_op_e op, input logic [31:0] arg,
                                          input ipv4_hdr_t h);
        ipv4_hdr_t r;
        r = h;
        case (op)
            OP_DEC_TTL: begin
                // TTL 0 stays put
                if (h.ttl != 8'd0) begin
                    r.ttl      = h.ttl - 8'd1;
                    r.checksum = adjust(h.checksum, {h.ttl, h.protocol}, {r.ttl, h.protocol});
                end
            end
            OP_SET_TOS: begin
                r.tos      = arg[7:0];
                r.checksum = adjust(h.checksum, {h.ver_ihl, h.tos}, {h.ver_ihl, arg[7:0]});
            end
            OP_SET_SRC: begin
                r.src_addr = arg;
                r.checksum = adjust(adjust(h.checksum, h.src_addr[31:16], arg[31:16]),
                                    h.src_addr[15:0], arg[15:0]);
            end
            OP_SET_DST: begin
                r.dst_addr = arg;
                r.checksum = adjust(adjust(h.checksum, h.dst_addr[31:16], arg[31:16]),
                                    h.dst_addr[15:0], arg[15:0]);
            end
            default: ;
        endcase
        return r;
    endfunction

    // Random header; damage flips a nonzero low byte so the sum always breaks
    function automatic ipv4_hdr_t make_hdr(input logic force_ttl, input logic [7:0] ttl,
                                           input logic corrupt);
        ipv4_hdr_t h;
        h         = {$urandom, $urandom, $urandom, $urandom, $urandom};
        h.ver_ihl = 8'h45;
        if (force_ttl)
            h.ttl = ttl;
        h.checksum = 16'h0;
        h.checksum = ~hdr_sum(h);
        if (corrupt)
            h.checksum = h.checksum ^ {8'h00, 8'($urandom_range(255, 1))};
        return h;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // Response checker
    ////////////////////////////////////////////////////////////////////////

    task automatic check_rsp();
        exp_t e;
        if (cycle > 0 && $isunknown(rsp.valid)) begin
            $display("rsp.valid is unknown at cycle %0d", cycle);
            errors++;
        end
        if (rsp.valid !== 1'b1) begin
            if (expect_q.size() != 0 && expect_q[0].due <= cycle) begin
                $display("Missing response: beat due at cycle %0d never came", expect_q[0].due);
                errors++;
                void'(expect_q.pop_front());
            end
        end else if (expect_q.size() == 0) begin
            $display("Unexpected response beat at cycle %0d with nothing outstanding", cycle);
            errors++;
        end else begin
            e = expect_q.pop_front();
            checked++;
            if (e.due != cycle) begin
                $display("Response came at cycle %0d but was due at cycle %0d", cycle, e.due);
                errors++;
            end
            if (rsp.hdr !== e.hdr) begin
                $display("error at %0t: header got %h expected %h", $time, rsp.hdr, e.hdr);
                errors++;
            end
            if (rsp.bad !== e.bad) begin
                $display("error at %0t: bad got %b expected %b", $time, rsp.bad, e.bad);
                errors++;
            end
            // Clean headers must still verify after the rewrite
            if (!e.bad && hdr_sum(rsp.hdr) != 16'hffff) begin
                $display("error at %0t: rewritten header sums to %h", $time, hdr_sum(rsp.hdr));
                errors++;
            end
        end
    endtask

    // Outputs settle after the rising edge, so look at the falling one
    always @(negedge update_req) begin
        check_rsp();
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////

    task automatic send(input rewrite_op_e op, input logic [31:0] arg, input ipv4_hdr_t h);
        exp_t e;
        @(negedge update_req);
        req.valid = 1'b1;
        req.op    = op;
        req.arg   = arg;
        req.hdr   = h;
        // Seen on rsp at the falling edge LATENCY cycles from now
        e.due = cycle + `IPV4_RW_LATENCY;
        e.hdr = rewrite(op, arg, h);
        e.bad = (hdr_sum(h) != 16'hffff);
        expect_q.push_back(e);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge update_req);
            req.valid = 1'b0;
        end
    endtask

    // Kind 2 TTL, 3 TOS/none, 4 addresses, 5 damaged headers, 6 random gaps
    task automatic run_test(input string name, input int kind);
        int          err0;
        int          gap;
        logic        corrupt;
        rewrite_op_e op;
        ipv4_hdr_t   h;
        err0 = errors;
        for (int i = 0; i < N_REQ; i++) begin
            gap     = 0;
            corrupt = 1'b0;
            case (kind)
                2:       op = OP_DEC_TTL;
                3:       op = ($urandom_range(1, 0) != 0) ? OP_SET_TOS : OP_NONE;
                4:       op = ($urandom_range(1, 0) != 0) ? OP_SET_SRC : OP_SET_DST;
                default: op = rewrite_op_e'($urandom_range(4, 0));
            endcase
            if (kind >= 5)
                corrupt = ($urandom_range((kind == 5) ? 1 : 3, 0) == 0);
            if (kind == 6)
                gap = $urandom_range(3, 0);
            // TTL 0 and 1 on every other pair of TTL requests
            h = make_hdr(kind == 2 && i % 4 < 2, 8'(i % 4), corrupt);
            send(op, $urandom, h);
            idle(gap);
        end
        idle(1);
        while (expect_q.size() != 0)
            @(negedge update_req);
        // Room for stray beats to show up
        idle(`IPV4_RW_LATENCY + 1);
        tests++;
        $display("test %0d %s: %0s, %0d errors", tests, name,
                 (errors == err0) ? "ok" : "failing", errors - err0);
    endtask

    ////////////////////////////////////////////////////////////////////////
    // Sequence and timeout
    ////////////////////////////////////////////////////////////////////////

    initial begin
        req = '0;
        void'($urandom(32'he45e_f82e));
        wait (rst == 1'b0);
        idle(10);
        tests++;
        $display("test 1 reset and idle: %0s", (errors == 0) ? "ok" : "failing");
        run_test("ttl decrement", 2);
        run_test("tos and no-op", 3);
        run_test("address replace", 4);
        run_test("damaged checksum", 5);
        run_test("back-to-back with gaps", 6);
        $display("tests %0d, beats checked %0d, errors %0d", tests, checked, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        wait (cycle >= TIMEOUT);
        $display("Timeout: run stopped after %0d cycles with %0d responses outstanding",
                 cycle, expect_q.size());
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+source
source/ipv4_rewrite_pkg.sv
source/ipv4_field_select.sv
source/ipv4_checksum_verify.sv
source/ipv4_checksum_update.sv
source/ipv4_header_rewriter.sv
verif/tb_clock_gen.sv
verif/tb_ipv4_header_rewriter.sv
